// ==== run_sim.sh ====
#!/bin/sh
# compile and run the fdiv testbench with verilator, everything logged to sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_fdiv_top -o tb_fdiv_top \
  > sim.log 2>&1 || { echo "build failed, see sim.log"; exit 1; }
./obj_dir/tb_fdiv_top >> sim.log 2>&1
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no pass message, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== sim.f ====
+incdir+source
source/fdiv_pkg.sv
source/fdiv_pipe_regs.sv
source/fdiv_iter_unit.sv
source/fdiv_ctrl.sv
source/fdiv_top.sv
verif/tb_fdiv_top.sv

// ==== source/fdiv_ctrl.sv ====
// ------------------------------------------------
// handshake control around the iterative divider
// one division at a time, a refused result waits
// in the hold register, flush abandons the op
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fdiv_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  // from input pipeline
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  fdiv_pkg::in_payload_t  in_data_i,
  // divider side
  output logic                   start_o,
  output fdiv_pkg::fp32_t        operand_a_o,
  output fdiv_pkg::fp32_t        operand_b_o,
  input  logic                   done_i,
  input  fdiv_pkg::fp32_t        unit_result_i,
  input  logic                   unit_inexact_i,
  // to output pipeline
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output fdiv_pkg::out_payload_t out_data_o,
  output logic                   busy_o
);

  fdiv_pkg::ctrl_state_e state_q, state_d;
  logic                  hold_result;    // capture the refused result
  logic                  data_is_held;   // output comes from hold register
  fdiv_pkg::tag_t        tag_q;
  fdiv_pkg::fp32_t       held_result_q;
  fdiv_pkg::status_t     unit_status, held_status_q;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb begin : ctrl_fsm
    in_ready_o   = 1'b0;
    out_valid_o  = 1'b0;
    hold_result  = 1'b0;
    data_is_held = 1'b0;
    state_d      = state_q;

    unique case (state_q)
      fdiv_pkg::IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) state_d = fdiv_pkg::BUSY;
      end
      fdiv_pkg::BUSY: begin
        if (done_i) begin
          out_valid_o = 1'b1;              // result offered in the done cycle
          if (out_ready_i) begin
            state_d = fdiv_pkg::IDLE;
            if (in_valid_i) begin          // back to back, next op starts now
              in_ready_o = 1'b1;
              state_d    = fdiv_pkg::BUSY;
            end
          end else begin
            hold_result = 1'b1;
            state_d     = fdiv_pkg::HOLD;
          end
        end
      end
      fdiv_pkg::HOLD: begin
        data_is_held = 1'b1;
        out_valid_o  = 1'b1;
        if (out_ready_i) begin
          state_d = fdiv_pkg::IDLE;
          if (in_valid_i) begin
            in_ready_o = 1'b1;
            state_d    = fdiv_pkg::BUSY;
          end
        end
      end
      default: state_d = fdiv_pkg::IDLE;
    endcase

    // flush wins over everything above
    if (flush_i) begin
      in_ready_o  = 1'b0;
      out_valid_o = 1'b0;
      hold_result = 1'b0;
      state_d     = fdiv_pkg::IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= fdiv_pkg::IDLE;
    else          state_q <= state_d;
  end

  assign start_o     = in_valid_i & in_ready_o;
  assign operand_a_o = in_data_i.operand_a;
  assign operand_b_o = in_data_i.operand_b;
  assign busy_o      = (state_q != fdiv_pkg::IDLE);

  // --------------------------------------------------
  // tag and hold registers
  // --------------------------------------------------
  assign unit_status = '{nv: 1'b0, dz: 1'b0, of: 1'b0, uf: 1'b0, nx: unit_inexact_i};

  always_ff @(posedge clk_i) begin
    if (start_o) tag_q <= in_data_i.tag;   // travels with the running op
    if (hold_result) begin
      held_result_q <= unit_result_i;
      held_status_q <= unit_status;
    end
  end

  assign out_data_o.result = data_is_held ? held_result_q : unit_result_i;
  assign out_data_o.status = data_is_held ? held_status_q : unit_status;
  assign out_data_o.tag    = tag_q;

  a_idle_no_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == fdiv_pkg::IDLE) |-> !out_valid_o)
    else $error("result offered while idle");

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == fdiv_pkg::HOLD) && ($past(state_q) == fdiv_pkg::HOLD) |-> $stable(out_data_o))
    else $error("held result changed");

endmodule

`default_nettype wire

// ==== source/fdiv_iter_unit.sv ====
// ------------------------------------------------
// iterative fp32 significand divider
// one quotient bit per cycle, done 26 cycles after
// start, truncating, normal operands and results
// only, no special value or range handling
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fdiv_params.svh"

module fdiv_iter_unit (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  logic            start_i,      // only while idle
  input  fdiv_pkg::fp32_t operand_a_i,
  input  fdiv_pkg::fp32_t operand_b_i,
  output logic            done_o,       // one cycle pulse
  output fdiv_pkg::fp32_t result_o,
  output logic            inexact_o
);

  localparam int SIG_W   = `FDIV_MAN_W + 1;          // significand with hidden bit
  localparam int Q_W     = `FDIV_ITERS;              // quotient bits 24..0
  localparam int CNT_W   = $clog2(`FDIV_ITERS);
  localparam int EXP_C_W = `FDIV_EXP_W + 2;          // room for the difference

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;    // iterations already done

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == CNT_W'(`FDIV_ITERS - 1)) begin  // last quotient bit this cycle
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  assign done_o = done_q;

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  logic [SIG_W-1:0]   divisor_q;
  logic [SIG_W:0]     rem_q;       // partial remainder, always below 2*divisor
  logic [Q_W-1:0]     quot_q;
  logic [EXP_C_W-1:0] exp_q;       // biased exponent before normalization
  logic               sign_q;
  logic               rem_ge;
  logic [SIG_W:0]     rem_diff;

  assign rem_ge   = rem_q >= {1'b0, divisor_q};
  assign rem_diff = rem_q - {1'b0, divisor_q};

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_q     <= {2'b01, operand_a_i.mantissa};   // sig a, the << 24 is implicit
      divisor_q <= {1'b1, operand_b_i.mantissa};
      exp_q     <= {2'b00, operand_a_i.exponent} - {2'b00, operand_b_i.exponent}
                   + EXP_C_W'(`FDIV_EXP_BIAS);
      sign_q    <= operand_a_i.sign ^ operand_b_i.sign;
    end else if (busy_q) begin
      // restoring step, both branches stay below 2^24 before the shift
      if (rem_ge) begin
        rem_q <= {rem_diff[SIG_W-1:0], 1'b0};
      end else begin
        rem_q <= {rem_q[SIG_W-1:0], 1'b0};
      end
      quot_q <= {quot_q[Q_W-2:0], rem_ge};
    end
  end

  // --------------------------------------------------
  // normalization, quotient lies in [2^23, 2^25)
  // --------------------------------------------------
  logic [`FDIV_MAN_W-1:0] man_norm;
  logic [EXP_C_W-1:0]     exp_norm;
  logic                   dropped_bit;

  always_comb begin
    if (quot_q[Q_W-1]) begin
      man_norm    = quot_q[Q_W-2:1];    // top bit is the hidden one
      exp_norm    = exp_q;
      dropped_bit = quot_q[0];
    end else begin
      man_norm    = quot_q[Q_W-3:0];
      exp_norm    = exp_q - 1'b1;
      dropped_bit = 1'b0;               // nothing below bit 0
    end
  end

  assign result_o  = {sign_q, exp_norm[`FDIV_EXP_W-1:0], man_norm};
  assign inexact_o = (rem_q != '0) | dropped_bit;

  // the control FSM must wait for done before the next start
  a_no_restart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> !busy_q)
    else $error("divider started while counting");

endmodule

`default_nettype wire

// ==== source/fdiv_params.svh ====
// ------------------------------------------------
// widths and defaults for the fp32 divider
// register counts are only defaults, fdiv_top
// takes them as parameters
// ------------------------------------------------
`ifndef FDIV_PARAMS_SVH
`define FDIV_PARAMS_SVH

// ieee single precision layout
`define FDIV_FP_W      32
`define FDIV_EXP_W     8
`define FDIV_MAN_W     23
`define FDIV_EXP_BIAS  127

`define FDIV_TAG_W     4   // caller tag
`define FDIV_ITERS     25  // quotient bits, one per cycle

// default pipeline depths around the divider
`define FDIV_NUM_INP_REGS 1
`define FDIV_NUM_OUT_REGS 1

`endif

// ==== source/fdiv_pipe_regs.sv ====
// ------------------------------------------------
// elastic valid/ready register chain
// NUM_REGS = 0 gives plain wires, ready is always
// combinational back to the input
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fdiv_pipe_regs #(
  parameter int unsigned NUM_REGS  = 1,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,      // drops every item in the chain
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o,
  output logic     any_valid_o   // some stage holds an item
);

  // index i is the signal after i stages, index 0 is the input side
  logic     valid_q [0:NUM_REGS];
  payload_t data_q  [0:NUM_REGS];
  logic     ready   [0:NUM_REGS];

  assign valid_q[0]       = in_valid_i;
  assign data_q[0]        = in_data_i;
  assign in_ready_o       = ready[0];
  assign ready[NUM_REGS]  = out_ready_i;   // downstream closes the chain

  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_stage
    // a stage may load when the next one moves on or holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // payload only moves with a real item
    always_ff @(posedge clk_i) begin
      if (ready[i] && valid_q[i]) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  assign out_valid_o = valid_q[NUM_REGS];
  assign out_data_o  = data_q[NUM_REGS];

  always_comb begin
    any_valid_o = 1'b0;
    for (int i = 1; i <= NUM_REGS; i++) begin
      any_valid_o = any_valid_o | valid_q[i];
    end
  end

  // a stalled item keeps its data until taken
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(out_data_o))
    else $error("pipe output changed while stalled");

endmodule

`default_nettype wire

// ==== source/fdiv_pkg.sv ====
// ------------------------------------------------
// shared types of the fp32 divider
// status only ever carries the inexact flag
// ------------------------------------------------
`default_nettype none

`include "fdiv_params.svh"

package fdiv_pkg;

  typedef struct packed {
    logic                   sign;
    logic [`FDIV_EXP_W-1:0] exponent;
    logic [`FDIV_MAN_W-1:0] mantissa;
  } fp32_t;

  // flag order as in the usual fp status word
  typedef struct packed {
    logic nv;  // invalid
    logic dz;  // divide by zero
    logic of;  // overflow
    logic uf;  // underflow
    logic nx;  // inexact
  } status_t;

  typedef logic [`FDIV_TAG_W-1:0] tag_t;

  typedef struct packed {
    fp32_t operand_a;  // dividend
    fp32_t operand_b;  // divisor
    tag_t  tag;
  } in_payload_t;

  typedef struct packed {
    fp32_t   result;
    status_t status;
    tag_t    tag;
  } out_payload_t;

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/fdiv_top.sv ====
// ------------------------------------------------
// fp32 divider with valid/ready on both sides
// latency NUM_INP_REGS + 26 + NUM_OUT_REGS, one op
// in the divider, normal operands and results only
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fdiv_params.svh"

module fdiv_top #(
  parameter int unsigned NUM_INP_REGS = `FDIV_NUM_INP_REGS,
  parameter int unsigned NUM_OUT_REGS = `FDIV_NUM_OUT_REGS
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  fdiv_pkg::fp32_t   operand_a_i,   // dividend
  input  fdiv_pkg::fp32_t   operand_b_i,   // divisor
  input  fdiv_pkg::tag_t    tag_i,
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output fdiv_pkg::fp32_t   result_o,
  output fdiv_pkg::status_t status_o,
  output fdiv_pkg::tag_t    tag_o,
  output logic              busy_o
);

  if ($bits(fdiv_pkg::fp32_t) != `FDIV_FP_W) begin : gen_width_check
    $error("fp32_t does not match FDIV_FP_W");
  end

  fdiv_pkg::in_payload_t  in_pkt, ctrl_in_pkt;
  fdiv_pkg::out_payload_t ctrl_out_pkt, out_pkt;
  logic                   ctrl_in_valid, ctrl_in_ready;
  logic                   ctrl_out_valid, ctrl_out_ready;
  logic                   inp_busy, ctrl_busy, out_busy;
  logic                   unit_start, unit_done, unit_inexact;
  fdiv_pkg::fp32_t        unit_op_a, unit_op_b, unit_result;

  assign in_pkt = '{operand_a: operand_a_i, operand_b: operand_b_i, tag: tag_i};

  fdiv_pipe_regs #(
    .NUM_REGS  (NUM_INP_REGS),
    .payload_t (fdiv_pkg::in_payload_t)
  ) u_inp_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_pkt),
    .out_valid_o (ctrl_in_valid),
    .out_ready_i (ctrl_in_ready),
    .out_data_o  (ctrl_in_pkt),
    .any_valid_o (inp_busy)
  );

  fdiv_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .in_valid_i     (ctrl_in_valid),
    .in_ready_o     (ctrl_in_ready),
    .in_data_i      (ctrl_in_pkt),
    .start_o        (unit_start),
    .operand_a_o    (unit_op_a),
    .operand_b_o    (unit_op_b),
    .done_i         (unit_done),
    .unit_result_i  (unit_result),
    .unit_inexact_i (unit_inexact),
    .out_valid_o    (ctrl_out_valid),
    .out_ready_i    (ctrl_out_ready),
    .out_data_o     (ctrl_out_pkt),
    .busy_o         (ctrl_busy)
  );

  fdiv_iter_unit u_unit (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .start_i     (unit_start),
    .operand_a_i (unit_op_a),
    .operand_b_i (unit_op_b),
    .done_o      (unit_done),
    .result_o    (unit_result),
    .inexact_o   (unit_inexact)
  );

  fdiv_pipe_regs #(
    .NUM_REGS  (NUM_OUT_REGS),
    .payload_t (fdiv_pkg::out_payload_t)
  ) u_out_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (ctrl_out_valid),
    .in_ready_o  (ctrl_out_ready),
    .in_data_i   (ctrl_out_pkt),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_pkt),
    .any_valid_o (out_busy)
  );

  assign result_o = out_pkt.result;
  assign status_o = out_pkt.status;
  assign tag_o    = out_pkt.tag;
  assign busy_o   = inp_busy | ctrl_busy | out_busy;   // anything in flight

endmodule

`default_nettype wire

// ==== verif/tb_fdiv_top.sv ====
// ------------------------------------------------
// directed testbench for fdiv_top, default depths
// inputs change 1 ns after posedge, outputs are
// sampled at negedge, first error ends the run
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fdiv_params.svh"

module tb_fdiv_top;

  localparam int LATENCY      = `FDIV_NUM_INP_REGS + `FDIV_ITERS + 1 + `FDIV_NUM_OUT_REGS;
  localparam int RESET_CYCLES = 10;
  localparam int STALL_CYCLES = 40;
  localparam int OPS_IN_RUN   = 51;      // all operations of all tests
  localparam int OP_CYCLES    = 30;      // one op through the DUT, a little over LATENCY
  localparam int DRAIN_CYCLES = 4 * OP_CYCLES;   // a few queued ops at most
  localparam int TIMEOUT_CYCLES =
    10 * (OPS_IN_RUN * OP_CYCLES + RESET_CYCLES + STALL_CYCLES + 100);
  localparam int EXP_LO   = 100;         // operand exponents 100..154 keep results normal
  localparam int EXP_SPAN = 55;

  logic                   clk, rst_n, flush, in_valid, in_ready, out_valid, out_ready, busy;
  fdiv_pkg::fp32_t        op_a, op_b, result;
  fdiv_pkg::status_t      status;
  fdiv_pkg::tag_t         tag_in, tag_out;

  fdiv_pkg::out_payload_t exp_q[$];      // scoreboard, oldest first
  fdiv_pkg::out_payload_t exp_pkt;
  fdiv_pkg::fp32_t        last_result;
  fdiv_pkg::status_t      last_status;
  fdiv_pkg::tag_t         last_tag;
  int                     cycle_cnt, xfer_cycle, last_out_cycle;
  integer                 seed = 84;

  fdiv_top u_fdiv_top (
    .clk_i (clk), .rst_n_i (rst_n), .flush_i (flush),
    .in_valid_i (in_valid), .in_ready_o (in_ready),
    .operand_a_i (op_a), .operand_b_i (op_b), .tag_i (tag_in),
    .out_valid_o (out_valid), .out_ready_i (out_ready),
    .result_o (result), .status_o (status), .tag_o (tag_out), .busy_o (busy)
  );

  always #10 clk = ~clk;   // 20 ns period

  // --------------------------------------------------
  // checking helpers
  // --------------------------------------------------
  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_result(input fdiv_pkg::fp32_t got, input fdiv_pkg::fp32_t exp,
                              input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s result %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_status(input fdiv_pkg::status_t got, input fdiv_pkg::status_t exp,
                              input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s status %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_tag(input fdiv_pkg::tag_t got, input fdiv_pkg::tag_t exp,
                           input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s tag %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // truncating divide of the significands, 25 quotient bits
  function automatic fdiv_pkg::out_payload_t model_div(input fdiv_pkg::fp32_t a,
                                                       input fdiv_pkg::fp32_t b,
                                                       input fdiv_pkg::tag_t tag);
    logic [63:0]            num, den, quo, rem;
    int                     e;
    fdiv_pkg::out_payload_t r;
    num = 64'({1'b1, a.mantissa}) << 24;
    den = 64'({1'b1, b.mantissa});
    quo = num / den;
    rem = num % den;
    e   = int'(a.exponent) - int'(b.exponent) + `FDIV_EXP_BIAS;
    r   = '0;
    r.tag = tag;
    r.result.sign = a.sign ^ b.sign;
    if (quo[24]) begin
      r.result.mantissa = quo[23:1];
      r.status.nx       = (rem != 0) || quo[0];
    end else begin                  // quotient below one, shift up
      r.result.mantissa = quo[22:0];
      r.status.nx       = (rem != 0);
      e = e - 1;
    end
    r.result.exponent = e[7:0];
    return r;
  endfunction

  function automatic fdiv_pkg::fp32_t random_operand();
    fdiv_pkg::fp32_t op;
    op.sign     = 1'($random(seed));
    op.exponent = 8'(EXP_LO + ($unsigned($random(seed)) % EXP_SPAN));
    op.mantissa = 23'($random(seed));
    return op;
  endfunction

  // --------------------------------------------------
  // driving, monitor, timeout
  // --------------------------------------------------
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // called 1 ns after an edge, returns 1 ns after the transfer edge
  task automatic send_op(input fdiv_pkg::fp32_t a, input fdiv_pkg::fp32_t b,
                         input fdiv_pkg::tag_t tag, input bit expect_out);
    bit taken;
    taken    = 1'b0;
    in_valid = 1'b1;
    op_a     = a;
    op_b     = b;
    tag_in   = tag;
    while (!taken) begin
      @(negedge clk);
      if (in_ready) begin
        taken      = 1'b1;
        xfer_cycle = cycle_cnt + 1;
        if (expect_out) begin
          exp_q.push_back(model_div(a, b, tag));
        end
      end
      tick();
    end
    in_valid = 1'b0;
  endtask

  // every expected result must come out within a bounded time
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      tick();
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d results never came out of the DUT", exp_q.size());
      stop_with_failure();
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("a result came out at %0t ns with no operation pending", $time);
        stop_with_failure();
      end else begin
        exp_pkt = exp_q.pop_front();
        check_result(result, exp_pkt.result, "output");
        check_status(status, exp_pkt.status, "output");
        check_tag(tag_out, exp_pkt.tag, "output");
        last_result    = result;
        last_status    = status;
        last_tag       = tag_out;
        last_out_cycle = cycle_cnt + 1;   // taken at the coming edge
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic exact_division();
    @(negedge clk);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(in_ready, 1'b1, "in_ready after reset");
    tick();
    send_op(32'h40C00000, 32'h3FC00000, 4'h5, 1'b1);   // 6.0 / 1.5
    wait_drained();
    check_result(last_result, 32'h40800000, "6.0/1.5");
    check_status(last_status, fdiv_pkg::status_t'(5'b00000), "6.0/1.5");
    check_tag(last_tag, 4'h5, "6.0/1.5");
    if (last_out_cycle - xfer_cycle != LATENCY) begin
      $display("Error at %0t ns: latency %0d cycles, expected %0d", $time,
               last_out_cycle - xfer_cycle, LATENCY);
      stop_with_failure();
    end
  endtask

  task automatic inexact_and_signs();
    logic [1:0] s;
    for (int i = 0; i < 4; i++) begin
      s = 2'(i);
      // 1/3 truncates to 0x3eaaaaaa
      send_op(32'h3F800000 | {s[1], 31'd0}, 32'h40400000 | {s[0], 31'd0}, 4'(i), 1'b1);
      wait_drained();
      check_result(last_result, 32'h3EAAAAAA | {s[1] ^ s[0], 31'd0}, "1/3");
      check_status(last_status, fdiv_pkg::status_t'(5'b00001), "1/3");
    end
  endtask

  task automatic random_stream();
    for (int i = 0; i < 40; i++) send_op(random_operand(), random_operand(), 4'(i), 1'b1);
    wait_drained();
  endtask

  task automatic backpressure_hold();
    out_ready = 1'b0;
    fork
      begin
        for (int i = 0; i < 4; i++) send_op(random_operand(), random_operand(), 4'(8 + i), 1'b1);
      end
      begin
        // first result parks in the output register, the next one waits in HOLD
        while (!out_valid) tick();
        repeat (STALL_CYCLES) tick();
        out_ready = 1'b1;
      end
    join
    wait_drained();
  endtask

  task automatic flush_mid_op();
    send_op(random_operand(), random_operand(), 4'hA, 1'b0);   // abandoned op
    repeat (12) tick();
    flush = 1'b1;
    tick();
    flush = 1'b0;
    repeat (LATENCY + 10) tick();      // a stray result would hit the monitor
    @(negedge clk);
    check_flag(busy, 1'b0, "busy after flush");
    tick();
    send_op(32'h40C00000, 32'h3FC00000, 4'hB, 1'b1);
    wait_drained();
    check_result(last_result, 32'h40800000, "division after flush");
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    op_a = '0;
    op_b = '0;
    tag_in = '0;
    cycle_cnt = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    exact_division();
    inexact_and_signs();
    random_stream();
    backpressure_hold();
    flush_mid_op();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
